// File: verif/golden_cmds.txt
// First value: clk_per_bit in hex
// Then one command per line: cmd addr data reply_flag expected_reply
0010
F0 00 00 1 AA
5C 10 3C 0 00
A3 10 00 1 3C
5C 20 7E 0 00
5C 30 C5 0 00
A3 30 00 1 C5
A3 20 00 1 7E
5C 20 81 0 00
A3 20 FF 1 81
12 10 99 0 00
A3 10 5A 1 3C
F0 77 55 1 AA
A3 30 E1 1 C5

// File: sim.f
+incdir+verilog
verilog/uart_pkg.sv
verilog/mon_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/mon_ram.sv
verilog/cmd_engine.sv
verilog/uart_monitor_top.sv
verif/tb_clock.sv
verif/uart_monitor_sva.sv
verif/tb_uart_monitor.sv

// File: Bender.yml
package:
  name: uart_monitor

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_pkg.sv
      - verilog/mon_pkg.sv
      - verilog/uart_rx.sv
      - verilog/uart_tx.sv
      - verilog/mon_ram.sv
      - verilog/cmd_engine.sv
      - verilog/uart_monitor_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/tb_clock.sv
      - verif/uart_monitor_sva.sv
      - verif/tb_uart_monitor.sv

// File: verif/tb_uart_monitor.sv
`timescale 1ns/1ps
`include "mon_params.svh"

module tb_uart_monitor;
    import uart_pkg::*;

    localparam int RST_CYCLES = 16;
    localparam int MAX_WORDS  = 128;
    // cmd, addr, data, reply flag, expected reply
    localparam int FIELDS     = 5;

    logic        clk;
    logic        rst;
    baud_cnt_t   clk_per_bit;
    logic        uart_rx;
    logic        uart_tx;

    logic [15:0] golden [MAX_WORDS];
    int          num_cmds;
    int          cpb;
    longint      cycle_limit = 64'h7FFF_FFFF_FFFF_FFFF;
    longint      cycles = 0;
    int          tx_falls = 0;
    byte_t       reply_q [$];
    logic [7:0]  lfsr;

    tb_clock u_clock (
        .clk (clk)
    );

    uart_monitor_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .clk_per_bit (clk_per_bit),
        .uart_rx     (uart_rx),
        .uart_tx     (uart_tx)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_values(input string test_name, input logic [15:0] expected,
                                  input logic [15:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h",
                                test_name, expected, actual));
        end
    endtask

    // Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        logic [7:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 8'hB8;
        end
        return next;
    endfunction

    task automatic draw_gap(output int bits);
        bits = 0;
        for (int i = 0; i < 4; i++) begin
            bits = (bits << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_byte(input byte_t data);
        logic [`DATA_BITS+1:0] frame;
        int                    gap;
        draw_gap(gap);
        repeat (gap * cpb) @(negedge clk);
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < `DATA_BITS + 2; i++) begin
            uart_rx = frame[i];
            repeat (cpb) @(negedge clk);
        end
    endtask

    // Reply decoder, samples near the middle of each bit
    always begin : reply_decoder
        byte_t shift;
        @(negedge clk);
        if (rst === 1'b0 && uart_tx === 1'b0) begin
            tx_falls++;
            repeat (cpb / 2 - 1) @(negedge clk);
            if (uart_tx !== 1'b0) begin
                abort_run("reply start bit did not stay low until mid-bit");
            end
            for (int i = 0; i < `DATA_BITS; i++) begin
                repeat (cpb) @(negedge clk);
                shift = {uart_tx, shift[`DATA_BITS-1:1]};
            end
            repeat (cpb) @(negedge clk);
            if (uart_tx !== 1'b1) begin
                abort_run("reply stop bit was not high");
            end
            reply_q.push_back(shift);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run($sformatf("timeout, run did not finish in %0d clock cycles", cycles));
        end
    end

    initial begin : main
        int    base;
        int    falls_before;
        byte_t cmd;
        byte_t addr;
        byte_t data;
        byte_t expected;
        logic  has_reply;
        string name;

        rst         = 1'b1;
        uart_rx     = 1'b1;
        clk_per_bit = '0;
        lfsr        = 8'd84;
        num_cmds    = 0;

        $readmemh("verif/golden_cmds.txt", golden);
        if ($isunknown(golden[0])) begin
            abort_run("golden file is missing or has no bit period");
        end
        cpb         = golden[0];
        clk_per_bit = baud_cnt_t'(cpb);
        while ((num_cmds + 1) * FIELDS + 1 <= MAX_WORDS &&
               !$isunknown(golden[(num_cmds + 1) * FIELDS])) begin
            num_cmds++;
        end
        // Six frames of 26 bit periods per golden line
        cycle_limit = longint'(num_cmds + 1) * 6 * 26 * cpb + RST_CYCLES;

        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        // Line must stay idle with nothing sent
        repeat (cpb) @(negedge clk);
        compare_values("idle line after reset", 1'b1, uart_tx);
        compare_values("no reply after reset", 0, tx_falls);

        for (int k = 0; k < num_cmds; k++) begin
            base      = 1 + k * FIELDS;
            cmd       = golden[base][7:0];
            addr      = golden[base + 1][7:0];
            data      = golden[base + 2][7:0];
            has_reply = golden[base + 3][0];
            expected  = golden[base + 4][7:0];
            name      = $sformatf("cmd %0d (%02h %02h %02h)", k, cmd, addr, data);

            falls_before = tx_falls;
            send_byte(cmd);
            send_byte(addr);
            send_byte(data);

            if (has_reply) begin
                while (reply_q.size() == 0) begin
                    @(negedge clk);
                end
                compare_values({name, " reply"}, expected, reply_q.pop_front());
                compare_values({name, " reply count"}, 1, tx_falls - falls_before);
                // Rest of the stop bit
                repeat (cpb / 2 + 1) @(negedge clk);
            end else begin
                repeat (12 * cpb) @(negedge clk);
                if (tx_falls != falls_before || reply_q.size() != 0) begin
                    abort_run($sformatf("%s sent a reply although none was expected", name));
                end
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: verif/uart_monitor_sva.sv
`timescale 1ns/1ps

module uart_monitor_sva (
    input logic                clk,
    input logic                rst,
    input logic                uart_tx,
    input logic                rx_done,
    input logic                tx_done,
    input logic                tx_start,
    input mon_pkg::eng_state_t eng_state
);
    import mon_pkg::*;

    // The first reset edge loads the idle frame
    tx_high_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> uart_tx)
        else $error("uart_tx is low while rst is high");

    // A launch from SEND_RESP puts the start bit on the line
    tx_start_launches_frame: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> eng_state == SEND_RESP ##1 !uart_tx)
        else $error("tx_start outside SEND_RESP or not followed by a start bit");

    rx_done_single: assert property (@(posedge clk) disable iff (rst)
        rx_done |=> !rx_done)
        else $error("rx_done lasted more than one cycle");

    tx_done_single: assert property (@(posedge clk) disable iff (rst)
        tx_done |=> !tx_done)
        else $error("tx_done lasted more than one cycle");

endmodule

bind uart_monitor_top uart_monitor_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .uart_tx   (uart_tx),
    .rx_done   (rx_done),
    .tx_done   (tx_done),
    .tx_start  (tx_start),
    .eng_state (u_engine.state)
);

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    localparam realtime HALF_PERIOD = 4.0;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

// File: verilog/uart_monitor_top.sv
`timescale 1ns/1ps

module uart_monitor_top (
    input  logic                clk,
    input  logic                rst,
    input  uart_pkg::baud_cnt_t clk_per_bit,
    input  logic                uart_rx,
    output logic                uart_tx
);
    import uart_pkg::*;
    import mon_pkg::*;

    byte_t rx_data;
    logic  rx_done;
    addr_t mem_addr;
    byte_t mem_din;
    logic  mem_we;
    byte_t mem_dout;
    byte_t tx_data;
    logic  tx_start;
    logic  tx_done;

    uart_rx u_rx (
        .clk         (clk),
        .rst         (rst),
        .clk_per_bit (clk_per_bit),
        .rx_line     (uart_rx),
        .rx_data     (rx_data),
        .rx_done     (rx_done)
    );

    mon_ram u_ram (
        .clk  (clk),
        .addr (mem_addr),
        .din  (mem_din),
        .we   (mem_we),
        .dout (mem_dout)
    );

    cmd_engine u_engine (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_done  (rx_done),
        .mem_dout (mem_dout),
        .tx_done  (tx_done),
        .mem_addr (mem_addr),
        .mem_din  (mem_din),
        .mem_we   (mem_we),
        .tx_data  (tx_data),
        .tx_start (tx_start)
    );

    uart_tx u_tx (
        .clk         (clk),
        .rst         (rst),
        .clk_per_bit (clk_per_bit),
        .tx_data     (tx_data),
        .tx_start    (tx_start),
        .tx_line     (uart_tx),
        .tx_done     (tx_done)
    );

endmodule

// File: verilog/cmd_engine.sv
`timescale 1ns/1ps
`include "mon_params.svh"

module cmd_engine (
    input  logic             clk,
    input  logic             rst,
    input  uart_pkg::byte_t  rx_data,
    input  logic             rx_done,
    input  uart_pkg::byte_t  mem_dout,
    input  logic             tx_done,
    output mon_pkg::addr_t   mem_addr,
    output uart_pkg::byte_t  mem_din,
    output logic             mem_we,
    output uart_pkg::byte_t  tx_data,
    output logic             tx_start
);
    import uart_pkg::*;
    import mon_pkg::*;

    eng_state_t state;
    eng_state_t next_state;
    byte_t      cmd_byte;
    addr_t      addr_byte;
    byte_t      data_byte;
    cmd_t       cmd_dec;

    assign cmd_dec = cmd_t'(cmd_byte);

    always_comb begin
        next_state = state;
        case (state)
            WAIT_CMD: begin
                if (rx_done) begin
                    next_state = WAIT_ADDR;
                end
            end
            WAIT_ADDR: begin
                if (rx_done) begin
                    next_state = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (rx_done) begin
                    next_state = EXEC;
                end
            end
            EXEC: begin
                case (cmd_dec)
                    CMD_READ, CMD_PING: next_state = SEND_RESP;
                    // Writes finish here, unknown codes are dropped
                    default:            next_state = WAIT_CMD;
                endcase
            end
            SEND_RESP: next_state = SEND_WAIT;
            SEND_WAIT: begin
                if (tx_done) begin
                    next_state = WAIT_CMD;
                end
            end
            default: next_state = WAIT_CMD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAIT_CMD;
        end else begin
            state <= next_state;
        end
    end

    // Command bytes and reply
    always_ff @(posedge clk) begin
        if (rx_done && state == WAIT_CMD) begin
            cmd_byte <= rx_data;
        end else if (rx_done && state == WAIT_ADDR) begin
            addr_byte <= rx_data;
        end else if (rx_done && state == WAIT_DATA) begin
            data_byte <= rx_data;
        end
        if (state == EXEC) begin
            tx_data <= (cmd_dec == CMD_PING) ? `PING_REPLY : mem_dout;
        end
    end

    assign mem_addr = addr_byte;
    assign mem_din  = data_byte;
    assign mem_we   = (state == EXEC) && (cmd_dec == CMD_WRITE);
    assign tx_start = (state == SEND_RESP);

endmodule

// File: verilog/mon_ram.sv
`timescale 1ns/1ps
`include "mon_params.svh"

module mon_ram (
    input  logic             clk,
    input  mon_pkg::addr_t   addr,
    input  uart_pkg::byte_t  din,
    input  logic             we,
    output uart_pkg::byte_t  dout
);
    import uart_pkg::*;

    byte_t mem [2**`ADDR_BITS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
    end

    // Asynchronous read
    assign dout = mem[addr];

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/1ps
`include "mon_params.svh"

module uart_tx (
    input  logic                clk,
    input  logic                rst,
    input  uart_pkg::baud_cnt_t clk_per_bit,
    input  uart_pkg::byte_t     tx_data,
    input  logic                tx_start,
    output logic                tx_line,
    output logic                tx_done
);
    import uart_pkg::*;

    // Start bit, data bits, stop bit
    localparam int FRAME_BITS = `DATA_BITS + 2;
    localparam int IDX_W      = $clog2(FRAME_BITS);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    tx_state_t              state;
    logic [FRAME_BITS-1:0]  frame;
    baud_cnt_t              cnt;
    logic [IDX_W-1:0]       bit_idx;

    // Frame refills with ones, so the line idles high
    assign tx_line = frame[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            frame   <= '1;
            cnt     <= '0;
            bit_idx <= '0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (tx_start) begin
                        frame <= {1'b1, tx_data, 1'b0};
                        state <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (cnt == clk_per_bit - 1'b1) begin
                        cnt     <= '0;
                        frame   <= {1'b1, frame[FRAME_BITS-1:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(FRAME_BITS - 1)) begin
                            tx_done <= 1'b1;
                            state   <= TX_IDLE;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/1ps
`include "mon_params.svh"

module uart_rx (
    input  logic                clk,
    input  logic                rst,
    input  uart_pkg::baud_cnt_t clk_per_bit,
    input  logic                rx_line,
    output uart_pkg::byte_t     rx_data,
    output logic                rx_done
);
    import uart_pkg::*;

    localparam int IDX_W = $clog2(`DATA_BITS);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t          state;
    logic               rx_meta;
    logic               rx_sync;
    baud_cnt_t          cnt;
    logic [IDX_W-1:0]   bit_idx;
    byte_t              shreg;
    logic               bit_end;
    logic               mid_start;

    assign bit_end   = (cnt == clk_per_bit - 1'b1);
    assign mid_start = (cnt == ((clk_per_bit - 1'b1) >> 1));

    // Two-flop synchronizer
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_start) begin
                        cnt <= '0;
                        // Line back high at mid-bit means a glitch
                        state <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == IDX_W'(`DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        rx_done <= 1'b1;
                        state   <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shreg <= {rx_sync, shreg[`DATA_BITS-1:1]};
        end
        if (state == RX_STOP && bit_end) begin
            rx_data <= shreg;
        end
    end

endmodule

// File: verilog/mon_pkg.sv
`include "mon_params.svh"

package mon_pkg;

    typedef logic [`ADDR_BITS-1:0] addr_t;

    typedef enum logic [`DATA_BITS-1:0] {
        CMD_READ  = `CMD_READ,
        CMD_WRITE = `CMD_WRITE,
        CMD_PING  = `CMD_PING
    } cmd_t;

    // Command engine states
    typedef enum logic [2:0] {
        WAIT_CMD,
        WAIT_ADDR,
        WAIT_DATA,
        EXEC,
        SEND_RESP,
        SEND_WAIT
    } eng_state_t;

endpackage

// File: verilog/uart_pkg.sv
`include "mon_params.svh"

package uart_pkg;

    // One serial data byte
    typedef logic [`DATA_BITS-1:0] byte_t;

    // Clock cycles per bit
    typedef logic [`CLK_BITS-1:0] baud_cnt_t;

endpackage

// File: verilog/mon_params.svh
`ifndef MON_PARAMS_SVH
`define MON_PARAMS_SVH

// Serial byte and memory word width
`define DATA_BITS 8
// Memory address width
`define ADDR_BITS 8
// Bit-period counter width
`define CLK_BITS 10

// Command codes
`define CMD_READ  8'hA3
`define CMD_WRITE 8'h5C
`define CMD_PING  8'hF0

// Fixed reply to a ping
`define PING_REPLY 8'hAA

`endif
